/* tb.f */
+incdir+verification
source/dcache_hit_pkg.sv
source/dcache_req_qual.sv
source/dcache_miss_fsm.sv
source/dcache_resp.sv
source/dcache_hit.sv
verification/dcache_hit_tb.sv

/* verification/dcache_hit_tb_table.svh */
`ifndef DCACHE_HIT_TB_TABLE_SVH
`define DCACHE_HIT_TB_TABLE_SVH

// kind of access one row exercises
typedef enum logic [2:0] {
  K_READ,
  K_WRITE,
  K_MISS_CLEAN,
  K_MISS_DIRTY,
  K_EXC
} kind_e;

// exc bits from bit 0 up are pma, pmp, misaligned and page fault
typedef struct packed {
  kind_e                 kind;
  dcache_hit_pkg::adr_t  adr;
  dcache_hit_pkg::word_t d;
  dcache_hit_pkg::be_t   be;
  logic [3:0]            exc;
  logic [31:0]           seed;
} row_t;

localparam int NUM_ROWS = 14;

row_t rows [NUM_ROWS];

function automatic row_t make_row(input kind_e kind, input logic [31:0] adr,
                                  input logic [31:0] d, input logic [3:0] be,
                                  input logic [3:0] exc, input logic [31:0] seed);
  return {kind, adr, d, be, exc, seed};
endfunction

task automatic load_table();
  //                 kind          address       data          be    exc   line seed
  rows[0]  = make_row(K_READ,       32'h0000_1004, 32'h0,        4'h0, 4'h0, 32'h5a1e_0001);
  rows[1]  = make_row(K_READ,       32'h8000_20a8, 32'h0,        4'h0, 4'h0, 32'h0b3c_7e12);
  rows[2]  = make_row(K_WRITE,      32'h0000_300c, 32'hcafe_f00d, 4'hf, 4'h0, 32'h1d2e_3f40);
  rows[3]  = make_row(K_WRITE,      32'h0001_4014, 32'h1234_5678, 4'h5, 4'h0, 32'h7788_99aa);
  rows[4]  = make_row(K_MISS_CLEAN, 32'h0000_5008, 32'h0,        4'h0, 4'h0, 32'h0000_0a0e);
  rows[5]  = make_row(K_READ,       32'h0000_5008, 32'h0,        4'h0, 4'h0, 32'h6b6c_6d6e);
  rows[6]  = make_row(K_MISS_DIRTY, 32'h0002_6034, 32'h0,        4'h0, 4'h0, 32'h3141_5927);
  rows[7]  = make_row(K_EXC,        32'h0000_7000, 32'h0,        4'h0, 4'h1, 32'h0);
  rows[8]  = make_row(K_EXC,        32'h0000_7010, 32'h0,        4'h0, 4'h2, 32'h0);
  rows[9]  = make_row(K_EXC,        32'h0000_7002, 32'h0,        4'h0, 4'h4, 32'h0);
  rows[10] = make_row(K_EXC,        32'h0000_7020, 32'h0,        4'h0, 4'h8, 32'h0);
  rows[11] = make_row(K_WRITE,      32'h0000_8000, 32'ha5a5_0ff0, 4'h8, 4'h0, 32'hfeed_0c0d);
  rows[12] = make_row(K_MISS_DIRTY, 32'h0003_900c, 32'h0,        4'h0, 4'h0, 32'h2718_2818);
  rows[13] = make_row(K_MISS_CLEAN, 32'h0004_a000, 32'h0,        4'h0, 4'h0, 32'h1414_2135);
endtask

`endif

/* verification/dcache_hit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_hit_tb;

  localparam int WAYS  = 2;
  localparam int LIMIT = 16;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             req_i;
  logic                             wreq_i;
  dcache_hit_pkg::adr_t             adr_i;
  dcache_hit_pkg::be_t              be_i;
  dcache_hit_pkg::word_t            d_i;
  logic                             cacheable_i;
  logic                             misaligned_i;
  logic                             pma_exception_i;
  logic                             pmp_exception_i;
  logic                             pagefault_i;
  dcache_hit_pkg::word_t            q_o;
  logic                             ack_o;
  logic                             err_o;
  logic                             misaligned_o;
  logic                             pagefault_o;
  logic                             stall_o;
  logic                             armed_o;
  logic                             filling_o;
  logic [WAYS-1:0]                  fill_way_i;
  logic [WAYS-1:0]                  fill_way_o;
  logic                             cache_hit_i;
  logic [WAYS-1:0]                  ways_hit_i;
  dcache_hit_pkg::line_t            cache_line_i;
  logic                             way_dirty_i;
  dcache_hit_pkg::idx_t             idx_o;
  dcache_hit_pkg::tag_t             core_tag_o;
  logic                             latchmem_o;
  logic                             recover_i;
  logic                             writebuffer_we_o;
  logic                             writebuffer_ack_i;
  dcache_hit_pkg::idx_t             writebuffer_idx_o;
  dcache_hit_pkg::dat_offs_t        writebuffer_offs_o;
  dcache_hit_pkg::word_t            writebuffer_data_o;
  dcache_hit_pkg::line_be_t         writebuffer_be_o;
  logic [WAYS-1:0]                  writebuffer_ways_hit_o;
  dcache_hit_pkg::idx_t             evict_idx_i;
  dcache_hit_pkg::tag_t             evict_tag_i;
  dcache_hit_pkg::line_t            evict_line_i;
  dcache_hit_pkg::adr_t             evictbuffer_adr_o;
  dcache_hit_pkg::line_t            evictbuffer_line_o;
  dcache_hit_pkg::biucmd_e          biucmd_o;
  logic                             biucmd_ack_i;
  logic                             biucmd_busy_i;
  dcache_hit_pkg::word_t            biu_q_i;
  logic                             biu_ack_i;
  logic                             biu_err_i;
  dcache_hit_pkg::adr_t             biu_adro_i;

  `include "dcache_hit_tb_table.svh"

  dcache_hit #(
    .WAYS (WAYS)
  ) dcache_hit_i (
    .*
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] act,
                             input logic [127:0] exp);
    if (act !== exp) begin
      $display("FAIL %0t ns %s: got %0h expected %0h", $time, name, act, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  // last resort against a stuck run
  initial begin
    #200000;
    stop_with_failure("simulation ran past its time limit");
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  task automatic drive_idle();
    req_i           = 1'b0;
    wreq_i          = 1'b0;
    misaligned_i    = 1'b0;
    pma_exception_i = 1'b0;
    pmp_exception_i = 1'b0;
    pagefault_i     = 1'b0;
    cache_hit_i     = 1'b0;
    biu_ack_i       = 1'b0;
    biucmd_ack_i    = 1'b0;
  endtask

  task automatic init_inputs();
    rst_ni            = 1'b0;
    adr_i             = '0;
    be_i              = '0;
    d_i               = '0;
    cacheable_i       = 1'b0;
    fill_way_i        = '0;
    ways_hit_i        = '0;
    cache_line_i      = '0;
    way_dirty_i       = 1'b0;
    recover_i         = 1'b0;
    writebuffer_ack_i = 1'b0;
    evict_idx_i       = '0;
    evict_tag_i       = '0;
    evict_line_i      = '0;
    biucmd_busy_i     = 1'b0;
    biu_q_i           = '0;
    biu_err_i         = 1'b0;
    biu_adro_i        = '0;
    drive_idle();
  endtask

  function automatic dcache_hit_pkg::line_t make_line(input logic [31:0] seed);
    dcache_hit_pkg::line_t line;
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = $urandom() ^ (seed + w);
    end
    return line;
  endfunction

  function automatic dcache_hit_pkg::word_t line_word(input dcache_hit_pkg::line_t line,
                                                      input logic [1:0] offs);
    return line[offs*32 +: 32];
  endfunction

  // each word owns four enable bits of the line
  function automatic dcache_hit_pkg::line_be_t line_enables(input dcache_hit_pkg::be_t be,
                                                            input logic [1:0] offs);
    dcache_hit_pkg::line_be_t en;
    en = '0;
    for (int b = 0; b < 4; b++) begin
      en[offs*4 + b] = be[b];
    end
    return en;
  endfunction

  // enabled store bytes replace the memory bytes
  function automatic dcache_hit_pkg::word_t merge_word(input dcache_hit_pkg::word_t word,
                                                       input dcache_hit_pkg::word_t d,
                                                       input dcache_hit_pkg::be_t be);
    dcache_hit_pkg::word_t merged;
    merged = word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) merged[b*8 +: 8] = d[b*8 +: 8];
    end
    return merged;
  endfunction

  // request strobes end at the first falling edge
  task automatic wait_ack(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_i);
      drive_idle();
      #1;
      cycles++;
    end while (!ack_o && cycles < LIMIT);
    if (!ack_o) stop_with_failure("no ack_o arrived within the time limit");
  endtask

  //////////////////////////////////////////////////
  // one task per kind of row
  //////////////////////////////////////////////////

  task automatic read_hit(input dcache_hit_pkg::adr_t adr, input dcache_hit_pkg::line_t line,
                          input dcache_hit_pkg::word_t expected);
    int cycles;
    @(negedge clk_i);
    req_i        = 1'b1;
    adr_i        = adr;
    cacheable_i  = 1'b1;
    cache_hit_i  = 1'b1;
    cache_line_i = line;
    #1;
    check_value("stall_o", stall_o, 1'b0);
    check_value("idx_o", idx_o, adr[7:4]);
    check_value("core_tag_o", core_tag_o, adr[31:8]);
    wait_ack(cycles);
    check_value("read ack latency", cycles, 1);
    check_value("q_o", q_o, expected);
  endtask

  task automatic write_hit(input row_t row);
    dcache_hit_pkg::line_t line;
    logic [1:0]            offs;
    int                    cycles;
    int                    hold;
    line = make_line(row.seed);
    offs = row.adr[3:2];
    @(negedge clk_i);
    wreq_i       = 1'b1;
    adr_i        = row.adr;
    d_i          = row.d;
    be_i         = row.be;
    cacheable_i  = 1'b1;
    cache_hit_i  = 1'b1;
    ways_hit_i   = 2'b10;
    cache_line_i = line;
    #1;
    check_value("stall_o", stall_o, 1'b0);
    wait_ack(cycles);
    check_value("write ack latency", cycles, 1);
    check_value("writebuffer_we_o", writebuffer_we_o, 1'b1);
    check_value("writebuffer_idx_o", writebuffer_idx_o, row.adr[7:4]);
    check_value("writebuffer_offs_o", writebuffer_offs_o, offs);
    check_value("writebuffer_data_o", writebuffer_data_o, row.d);
    check_value("writebuffer_be_o", writebuffer_be_o, line_enables(row.be, offs));
    check_value("writebuffer_ways_hit_o", writebuffer_ways_hit_o, 2'b10);
    hold = $urandom_range(1, 3);
    repeat (hold) begin
      @(negedge clk_i);
      #1;
      check_value("writebuffer_we_o", writebuffer_we_o, 1'b1);
    end
    // read the same word while the store is still pending
    line = make_line(row.seed ^ 32'hffff_0000);
    read_hit(row.adr, line, merge_word(line_word(line, offs), row.d, row.be));
    check_value("writebuffer_we_o", writebuffer_we_o, 1'b1);
    @(negedge clk_i);
    writebuffer_ack_i = 1'b1;
    #1;
    check_value("writebuffer_we_o", writebuffer_we_o, 1'b1);
    @(negedge clk_i);
    writebuffer_ack_i = 1'b0;
    #1;
    check_value("writebuffer_we_o", writebuffer_we_o, 1'b0);
  endtask

  task automatic fill_miss(input row_t row, input logic dirty);
    dcache_hit_pkg::line_t line;
    dcache_hit_pkg::tag_t  ev_tag;
    dcache_hit_pkg::word_t bus_word;
    logic [WAYS-1:0]       way;
    int                    cycles;
    int                    delay;
    line   = make_line(row.seed);
    ev_tag = dcache_hit_pkg::tag_t'($urandom());
    way    = row.seed[0] ? 2'b10 : 2'b01;
    @(negedge clk_i);
    req_i        = 1'b1;
    adr_i        = row.adr;
    cacheable_i  = 1'b1;
    cache_hit_i  = 1'b0;
    way_dirty_i  = dirty;
    fill_way_i   = way;
    evict_idx_i  = row.adr[7:4];
    evict_tag_i  = ev_tag;
    evict_line_i = line;
    #1;
    check_value("stall_o", stall_o, 1'b1);
    cycles = 0;
    do begin
      @(negedge clk_i);
      #1;
      cycles++;
    end while (biucmd_o == dcache_hit_pkg::BIUCMD_NOP && cycles < LIMIT);
    check_value("readway latency", cycles, 1);
    check_value("biucmd_o", biucmd_o, dcache_hit_pkg::BIUCMD_READWAY);
    check_value("filling_o", filling_o, 1'b1);
    check_value("armed_o", armed_o, 1'b0);
    check_value("fill_way_o", fill_way_o, way);
    // bus model answers with the requested word after a random delay
    delay = $urandom_range(1, 4);
    repeat (delay) begin
      @(negedge clk_i);
      evict_line_i = ~line;
      #1;
      check_value("biucmd_o", biucmd_o, dcache_hit_pkg::BIUCMD_NOP);
      check_value("stall_o", stall_o, 1'b1);
      check_value("ack_o", ack_o, 1'b0);
    end
    bus_word = $urandom();
    @(negedge clk_i);
    biu_ack_i  = 1'b1;
    biu_adro_i = row.adr;
    biu_q_i    = bus_word;
    #1;
    check_value("stall_o", stall_o, 1'b0);
    wait_ack(cycles);
    check_value("fill ack latency", cycles, 1);
    check_value("q_o", q_o, bus_word);
    if (dirty) begin
      check_value("evictbuffer_adr_o", evictbuffer_adr_o, {ev_tag, row.adr[7:4], 4'h0});
      check_value("evictbuffer_line_o", evictbuffer_line_o, line);
    end
    delay = $urandom_range(0, 3);
    repeat (delay) @(negedge clk_i);
    @(negedge clk_i);
    biucmd_ack_i = 1'b1;
    #1;
    // two recovery cycles with memory latched in the second
    cycles = 0;
    do begin
      @(negedge clk_i);
      biucmd_ack_i = 1'b0;
      #1;
      if (!armed_o) begin
        cycles++;
        check_value("stall_o", stall_o, 1'b1);
        check_value("latchmem_o", latchmem_o, cycles == 2);
        check_value("biucmd_o", biucmd_o, (dirty && cycles == 1) ?
                    dcache_hit_pkg::BIUCMD_WRITEWAY : dcache_hit_pkg::BIUCMD_NOP);
      end
    end while (!armed_o && cycles < LIMIT);
    check_value("recovery cycles", cycles, 2);
    check_value("filling_o", filling_o, 1'b0);
    check_value("stall_o", stall_o, 1'b0);
  endtask

  task automatic exception_req(input row_t row);
    @(negedge clk_i);
    req_i           = 1'b1;
    adr_i           = row.adr;
    cacheable_i     = 1'b1;
    cache_hit_i     = 1'b0;
    pma_exception_i = row.exc[0];
    pmp_exception_i = row.exc[1];
    misaligned_i    = row.exc[2];
    pagefault_i     = row.exc[3];
    #1;
    check_value("stall_o", stall_o, 1'b0);
    @(negedge clk_i);
    drive_idle();
    #1;
    check_value("err_o", err_o, row.exc[0] | row.exc[1]);
    check_value("misaligned_o", misaligned_o, row.exc[2]);
    check_value("pagefault_o", pagefault_o, row.exc[3]);
    check_value("ack_o", ack_o, 1'b0);
    check_value("biucmd_o", biucmd_o, dcache_hit_pkg::BIUCMD_NOP);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    dcache_hit_pkg::line_t line;
    void'($urandom(32'h0fa2_b857));
    init_inputs();
    load_table();
    repeat (16) @(negedge clk_i);
    check_value("armed_o", armed_o, 1'b1);
    check_value("filling_o", filling_o, 1'b0);
    check_value("ack_o", ack_o, 1'b0);
    check_value("writebuffer_we_o", writebuffer_we_o, 1'b0);
    check_value("biucmd_o", biucmd_o, dcache_hit_pkg::BIUCMD_NOP);
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      case (rows[i].kind)
        K_READ: begin
          line = make_line(rows[i].seed);
          read_hit(rows[i].adr, line, line_word(line, rows[i].adr[3:2]));
        end
        K_WRITE:      write_hit(rows[i]);
        K_MISS_CLEAN: fill_miss(rows[i], 1'b0);
        K_MISS_DIRTY: fill_miss(rows[i], 1'b1);
        default:      exception_req(rows[i]);
      endcase
    end
    repeat (4) @(negedge clk_i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* source/dcache_hit.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_hit #(
  parameter int WAYS = 2
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  // core side
  input  wire logic                      req_i,
  input  wire logic                      wreq_i,
  input  wire dcache_hit_pkg::adr_t      adr_i,
  input  wire dcache_hit_pkg::be_t       be_i,
  input  wire dcache_hit_pkg::word_t     d_i,
  input  wire logic                      cacheable_i,
  input  wire logic                      misaligned_i,
  input  wire logic                      pma_exception_i,
  input  wire logic                      pmp_exception_i,
  input  wire logic                      pagefault_i,
  output dcache_hit_pkg::word_t          q_o,
  output logic                           ack_o,
  output logic                           err_o,
  output logic                           misaligned_o,
  output logic                           pagefault_o,
  output logic                           stall_o,
  output logic                           armed_o,
  output logic                           filling_o,
  // tag and data memories
  input  wire logic [WAYS-1:0]           fill_way_i,
  output logic [WAYS-1:0]                fill_way_o,
  input  wire logic                      cache_hit_i,
  input  wire logic [WAYS-1:0]           ways_hit_i,
  input  wire dcache_hit_pkg::line_t     cache_line_i,
  input  wire logic                      way_dirty_i,
  output dcache_hit_pkg::idx_t           idx_o,
  output dcache_hit_pkg::tag_t           core_tag_o,
  output logic                           latchmem_o,
  input  wire logic                      recover_i,
  // write buffer
  output logic                           writebuffer_we_o,
  input  wire logic                      writebuffer_ack_i,
  output dcache_hit_pkg::idx_t           writebuffer_idx_o,
  output dcache_hit_pkg::dat_offs_t      writebuffer_offs_o,
  output dcache_hit_pkg::word_t          writebuffer_data_o,
  output dcache_hit_pkg::line_be_t       writebuffer_be_o,
  output logic [WAYS-1:0]                writebuffer_ways_hit_o,
  // evict buffer
  input  wire dcache_hit_pkg::idx_t      evict_idx_i,
  input  wire dcache_hit_pkg::tag_t      evict_tag_i,
  input  wire dcache_hit_pkg::line_t     evict_line_i,
  output dcache_hit_pkg::adr_t           evictbuffer_adr_o,
  output dcache_hit_pkg::line_t          evictbuffer_line_o,
  // bus interface
  output dcache_hit_pkg::biucmd_e        biucmd_o,
  input  wire logic                      biucmd_ack_i,
  input  wire logic                      biucmd_busy_i,
  input  wire dcache_hit_pkg::word_t     biu_q_i,
  input  wire logic                      biu_ack_i,
  input  wire logic                      biu_err_i,
  input  wire dcache_hit_pkg::adr_t      biu_adro_i
);

  logic                      valid_req;
  logic                      err_req;
  dcache_hit_pkg::dat_offs_t dat_offs;
  logic                      biu_word_ack;
  logic                      capture_evict;

  dcache_req_qual req_qual_i (
    .valid_req_o (valid_req),
    .err_req_o   (err_req),
    .dat_offs_o  (dat_offs),
    .*
  );

  dcache_miss_fsm #(
    .WAYS (WAYS)
  ) miss_fsm_i (
    .valid_req_i     (valid_req),
    .biu_word_ack_i  (biu_word_ack),
    .capture_evict_o (capture_evict),
    .*
  );

  dcache_resp #(
    .WAYS (WAYS)
  ) resp_i (
    .valid_req_i     (valid_req),
    .armed_i         (armed_o),
    .filling_i       (filling_o),
    .idx_i           (idx_o),
    .dat_offs_i      (dat_offs),
    .capture_evict_i (capture_evict),
    .err_req_i       (err_req),
    .biu_word_ack_o  (biu_word_ack),
    .*
  );

endmodule

`default_nettype wire

/* source/dcache_resp.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_resp #(
  parameter int WAYS = 2
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      valid_req_i,
  input  wire logic                      wreq_i,
  input  wire logic                      cacheable_i,
  input  wire logic                      cache_hit_i,
  input  wire logic                      armed_i,
  input  wire logic                      filling_i,
  input  wire dcache_hit_pkg::idx_t      idx_i,
  input  wire dcache_hit_pkg::dat_offs_t dat_offs_i,
  input  wire dcache_hit_pkg::be_t       be_i,
  input  wire dcache_hit_pkg::word_t     d_i,
  input  wire logic [WAYS-1:0]           ways_hit_i,
  input  wire dcache_hit_pkg::line_t     cache_line_i,
  input  wire logic                      writebuffer_ack_i,
  input  wire dcache_hit_pkg::idx_t      evict_idx_i,
  input  wire dcache_hit_pkg::tag_t      evict_tag_i,
  input  wire dcache_hit_pkg::line_t     evict_line_i,
  input  wire logic                      capture_evict_i,
  input  wire logic                      biu_ack_i,
  input  wire dcache_hit_pkg::adr_t      biu_adro_i,
  input  wire dcache_hit_pkg::word_t     biu_q_i,
  input  wire logic                      biu_err_i,
  input  wire logic                      err_req_i,
  input  wire dcache_hit_pkg::adr_t      adr_i,
  output logic                           biu_word_ack_o,
  output dcache_hit_pkg::word_t          q_o,
  output logic                           ack_o,
  output logic                           err_o,
  output logic                           writebuffer_we_o,
  output dcache_hit_pkg::idx_t           writebuffer_idx_o,
  output dcache_hit_pkg::dat_offs_t      writebuffer_offs_o,
  output dcache_hit_pkg::word_t          writebuffer_data_o,
  output dcache_hit_pkg::line_be_t       writebuffer_be_o,
  output logic [WAYS-1:0]                writebuffer_ways_hit_o,
  output dcache_hit_pkg::adr_t           evictbuffer_adr_o,
  output dcache_hit_pkg::line_t          evictbuffer_line_o
);

  localparam int XLEN          = dcache_hit_pkg::XLEN;
  localparam int PLEN          = dcache_hit_pkg::PLEN;
  localparam int BLK_BITS      = dcache_hit_pkg::BLK_BITS;
  localparam int BLK_OFFS_BITS = dcache_hit_pkg::BLK_OFFS_BITS;
  localparam int WORD_LSB      = $clog2(XLEN / 8);

  logic                  hit;
  logic                  wr_hit;
  logic                  bypass;
  logic                  biu_err_q;
  dcache_hit_pkg::line_t merged_line;
  dcache_hit_pkg::word_t cache_q;

  assign hit    = valid_req_i & cacheable_i & cache_hit_i;
  assign wr_hit = hit & wreq_i & armed_i;

  //////////////////////////////////////////////////
  // write buffer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      writebuffer_we_o <= 1'b0;
    end else if (wr_hit) begin
      writebuffer_we_o <= 1'b1;
    end else if (writebuffer_ack_i) begin
      writebuffer_we_o <= 1'b0;
    end
  end

  // byte enables move to their place in the line
  always_ff @(posedge clk_i) begin
    if (wr_hit) begin
      writebuffer_idx_o      <= idx_i;
      writebuffer_offs_o     <= dat_offs_i;
      writebuffer_data_o     <= d_i;
      writebuffer_be_o       <= dcache_hit_pkg::line_be_t'(be_i) << (dat_offs_i * (XLEN / 8));
      writebuffer_ways_hit_o <= ways_hit_i;
    end
  end

  // pending store to this set wins over the memory contents
  assign bypass = writebuffer_we_o & (idx_i == writebuffer_idx_o);

  always_comb begin
    merged_line = cache_line_i;
    for (int i = 0; i < BLK_BITS / 8; i++) begin
      if (bypass && writebuffer_be_o[i]) begin
        merged_line[i*8 +: 8] = writebuffer_data_o[(i % (XLEN / 8))*8 +: 8];
      end
    end
  end

  assign cache_q = merged_line[dat_offs_i*XLEN +: XLEN];

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  assign biu_word_ack_o = valid_req_i & biu_ack_i &
                          (biu_adro_i[PLEN-1:WORD_LSB] == adr_i[PLEN-1:WORD_LSB]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o     <= 1'b0;
      biu_err_q <= 1'b0;
    end else begin
      ack_o     <= (armed_i & hit) | (filling_i & biu_word_ack_o);
      biu_err_q <= biu_err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    q_o <= cache_hit_i ? cache_q : biu_q_i;
  end

  assign err_o = err_req_i | biu_err_q;

  // evict buffer keeps the old line until the write-way command
  always_ff @(posedge clk_i) begin
    if (capture_evict_i) begin
      evictbuffer_adr_o  <= {evict_tag_i, evict_idx_i, {BLK_OFFS_BITS{1'b0}}};
      evictbuffer_line_o <= evict_line_i;
    end
  end

  a_wb_needs_hit: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(writebuffer_we_o) |-> $past(wr_hit)
  );

endmodule

`default_nettype wire

/* source/dcache_miss_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_fsm #(
  parameter int WAYS = 2
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              valid_req_i,
  input  wire logic              cacheable_i,
  input  wire logic              cache_hit_i,
  input  wire logic              way_dirty_i,
  input  wire logic [WAYS-1:0]   fill_way_i,
  input  wire logic              biucmd_ack_i,
  input  wire logic              biucmd_busy_i,
  input  wire logic              biu_err_i,
  input  wire logic              biu_word_ack_i,
  input  wire logic              recover_i,
  output dcache_hit_pkg::biucmd_e biucmd_o,
  output logic [WAYS-1:0]        fill_way_o,
  output logic                   armed_o,
  output logic                   filling_o,
  output logic                   stall_o,
  output logic                   latchmem_o,
  output logic                   capture_evict_o
);

  typedef enum logic [2:0] {
    ARMED,
    READ,
    EVICT,
    RECOVER0,
    RECOVER1
  } state_e;

  state_e                  state;
  state_e                  nxt_state;
  dcache_hit_pkg::biucmd_e nxt_biucmd;
  logic [WAYS-1:0]         nxt_fill_way;
  logic                    miss;
  logic                    fill_done;

  assign miss      = valid_req_i & cacheable_i & ~cache_hit_i;
  assign fill_done = biucmd_ack_i | biu_err_i;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    nxt_state    = state;
    nxt_biucmd   = dcache_hit_pkg::BIUCMD_NOP;
    nxt_fill_way = fill_way_o;

    unique case (state)
      ARMED: begin
        if (miss && !biucmd_busy_i) begin
          // refill the way the memories picked
          nxt_fill_way = fill_way_i;
          nxt_biucmd   = dcache_hit_pkg::BIUCMD_READWAY;
          nxt_state    = way_dirty_i ? EVICT : READ;
        end
      end
      READ: begin
        if (fill_done) nxt_state = RECOVER0;
      end
      EVICT: begin
        // old line in the evict buffer goes back to memory now
        if (fill_done) begin
          nxt_state  = RECOVER0;
          nxt_biucmd = dcache_hit_pkg::BIUCMD_WRITEWAY;
        end
      end
      RECOVER0: nxt_state = RECOVER1;
      RECOVER1: nxt_state = ARMED;
      default:  nxt_state = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state      <= ARMED;
      biucmd_o   <= dcache_hit_pkg::BIUCMD_NOP;
      fill_way_o <= '0;
      armed_o    <= 1'b1;
      filling_o  <= 1'b0;
    end else begin
      state      <= nxt_state;
      biucmd_o   <= nxt_biucmd;
      fill_way_o <= nxt_fill_way;
      armed_o    <= (nxt_state == ARMED);
      filling_o  <= (nxt_state == READ) || (nxt_state == EVICT);
    end
  end

  //////////////////////////////////////////////////
  // stall and memory latch
  //////////////////////////////////////////////////

  // recover_i has no effect and both recovery cycles always run
  always_comb begin
    unique case (state)
      ARMED: begin
        stall_o    = miss;
        latchmem_o = ~miss;
      end
      READ, EVICT: begin
        // the requested word from the bus lets the core go on
        stall_o    = ~biu_word_ack_i;
        latchmem_o = biu_word_ack_i;
      end
      RECOVER0: begin
        stall_o    = 1'b1;
        latchmem_o = 1'b0;
      end
      RECOVER1: begin
        stall_o    = 1'b1;
        latchmem_o = 1'b1;
      end
      default: begin
        stall_o    = 1'b0;
        latchmem_o = 1'b1;
      end
    endcase
  end

  assign capture_evict_o = (state == ARMED);

  a_readway_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    biucmd_o == dcache_hit_pkg::BIUCMD_READWAY |=> biucmd_o != dcache_hit_pkg::BIUCMD_READWAY
  );

  // write-back follows the read-way acknowledge of a dirty miss
  a_writeway_after_evict: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    biucmd_o == dcache_hit_pkg::BIUCMD_WRITEWAY |-> $past(state) == EVICT && state == RECOVER0
  );

endmodule

`default_nettype wire

/* source/dcache_req_qual.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_req_qual (
  input  wire logic                 clk_i,
  input  wire logic                 req_i,
  input  wire logic                 wreq_i,
  input  wire logic                 misaligned_i,
  input  wire logic                 pma_exception_i,
  input  wire logic                 pmp_exception_i,
  input  wire logic                 pagefault_i,
  input  wire dcache_hit_pkg::adr_t adr_i,
  output logic                      valid_req_o,
  output logic                      err_req_o,
  output dcache_hit_pkg::idx_t      idx_o,
  output dcache_hit_pkg::tag_t      core_tag_o,
  output dcache_hit_pkg::dat_offs_t dat_offs_o,
  output logic                      misaligned_o,
  output logic                      pagefault_o
);

  localparam int PLEN          = dcache_hit_pkg::PLEN;
  localparam int BLK_OFFS_BITS = dcache_hit_pkg::BLK_OFFS_BITS;
  localparam int DAT_OFFS_BITS = dcache_hit_pkg::DAT_OFFS_BITS;
  localparam int IDX_BITS      = dcache_hit_pkg::IDX_BITS;
  localparam int TAG_BITS      = dcache_hit_pkg::TAG_BITS;

  logic req;
  logic prot_exc;

  // a store request counts on its own
  assign req      = req_i | wreq_i;
  assign prot_exc = pma_exception_i | pmp_exception_i;

  assign valid_req_o = req & ~prot_exc & ~misaligned_i & ~pagefault_i;

  // address fields
  assign idx_o      = adr_i[BLK_OFFS_BITS +: IDX_BITS];
  assign core_tag_o = adr_i[PLEN-1 -: TAG_BITS];
  assign dat_offs_o = adr_i[BLK_OFFS_BITS-1 -: DAT_OFFS_BITS];

  //////////////////////////////////////////////////
  // exceptions registered one cycle after the request
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    err_req_o    <= req & prot_exc;
    misaligned_o <= req & misaligned_i;
    pagefault_o  <= req & pagefault_i;
  end

  // a request that reaches the cache leaves no fault behind
  a_no_exc_after_valid: assert property (
    @(posedge clk_i)
    valid_req_o |=> !(err_req_o || misaligned_o || pagefault_o)
  );

endmodule

`default_nettype wire

/* source/dcache_hit_pkg.sv */
`default_nettype none

package dcache_hit_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int XLEN          = 32;
  localparam int PLEN          = 32;
  localparam int BLK_BITS      = 128;
  localparam int SETS          = 16;

  // offsets inside one line
  localparam int BLK_OFFS_BITS = $clog2(BLK_BITS / 8);
  localparam int DAT_OFFS_BITS = $clog2(BLK_BITS / XLEN);

  localparam int IDX_BITS      = $clog2(SETS);
  localparam int TAG_BITS      = PLEN - IDX_BITS - BLK_OFFS_BITS;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic [XLEN-1:0]          word_t;
  typedef logic [PLEN-1:0]          adr_t;
  typedef logic [XLEN/8-1:0]        be_t;
  typedef logic [BLK_BITS-1:0]      line_t;
  typedef logic [BLK_BITS/8-1:0]    line_be_t;
  typedef logic [IDX_BITS-1:0]      idx_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [DAT_OFFS_BITS-1:0] dat_offs_t;

  // commands towards the bus interface
  typedef enum logic [1:0] {
    BIUCMD_NOP      = 2'd0,
    BIUCMD_READWAY  = 2'd1,
    BIUCMD_WRITEWAY = 2'd2
  } biucmd_e;

endpackage

`default_nettype wire
